// File: verilog/sys_pkg.sv
// Shared widths, command codes, bus layouts and constants of the system top
// Field order of the packed structs is the bit order on the wire, MSB first
package sys_pkg;

	// ==================================================
	// Plain vector types
	// ==================================================
	typedef logic [15:0] host_word_t;
	typedef logic [31:0] status_word_t;
	typedef logic [11:0] timing_t;
	typedef logic [15:0] sample_t;
	typedef logic [1:0]  mix_mode_t;
	typedef logic [7:0]  cmd_code_t;
	typedef logic [1:0]  reset_code_t;
	typedef logic [3:0]  word_cnt_t;
	typedef logic [7:0]  deb_hist_t;

	// ==================================================
	// Constants
	// ==================================================
	localparam status_word_t CORE_MAGIC = 32'h5CA623A4;
	localparam logic [1:0]   IO_VER     = 2'd1;

	localparam cmd_code_t CMD_CFG    = 8'h01;
	localparam cmd_code_t CMD_TIMING = 8'h20;
	localparam cmd_code_t CMD_LED    = 8'h25;

	// Cross-mix amounts
	localparam mix_mode_t MIX_EIGHTH  = 2'd1;
	localparam mix_mode_t MIX_QUARTER = 2'd2;
	localparam mix_mode_t MIX_HALF    = 2'd3;

	localparam int        DEBOUNCE_DIV = 100000;
	localparam int        DEBOUNCE_W   = $clog2(DEBOUNCE_DIV + 1);
	localparam int        DEBOUNCE_LEN = 8;
	localparam word_cnt_t TIMING_WORDS = 4'd8;
	localparam int        SYNC_CNT_W   = 24;

	typedef logic [DEBOUNCE_W-1:0] debounce_div_t;
	typedef logic [SYNC_CNT_W-1:0] sync_cnt_t;

	// ==================================================
	// Structs and the decoder state
	// ==================================================
	typedef struct packed {
		logic        core_ready;
		reset_code_t reset_code;
		logic        disk_activity;
		logic        io_uio;
		logic        io_clk;
		host_word_t  io_din;
	} host_bus_t;

	typedef struct packed {
		timing_t width;
		timing_t hfp;
		timing_t hs;
		timing_t hbp;
		timing_t height;
		timing_t vfp;
		timing_t vs;
		timing_t vbp;
	} video_timing_t;

	typedef struct packed {
		logic dvi_mode;
		logic audio_96k;
		logic ypbpr_en;
		logic csync;
		logic vga_scaler;
	} sys_cfg_t;

	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_override_t;

	typedef enum logic {IDLE, HAVE_CMD} cmd_phase_t;

	// 1280x720 at 60 Hz, CEA timing
	localparam video_timing_t TIMING_RESET_DEFAULT = '{
		width: 12'd1280, hfp: 12'd110, hs: 12'd40, hbp: 12'd220,
		height: 12'd720, vfp: 12'd5, vs: 12'd5, vbp: 12'd20
	};

endpackage

// File: verilog/host_cmd_decoder.sv
// Host bus decoder; each phase of io_clk must last at least 8 clock cycles
// Registers update 4 cycles after the io_clk edge, io_ack lags io_clk by 4
// Timing words past the eighth are ignored
`timescale 1ns/100ps

module host_cmd_decoder (
	input  logic                   FPGA_CLK2_50,
	input  logic                   resetd,
	input  sys_pkg::host_bus_t     host_bus,
	input  logic                   btn_user,
	input  logic                   btn_osd,
	output sys_pkg::sys_cfg_t      cfg,
	output sys_pkg::video_timing_t video_timing,
	output sys_pkg::led_override_t led_override,
	output sys_pkg::reset_code_t   reset_code,
	output logic                   disk_activity,
	output sys_pkg::status_word_t  status
);

	sys_pkg::host_bus_t   bus_s1;
	sys_pkg::host_bus_t   bus_s2;
	logic                 rack;
	logic                 io_ack;
	logic                 strobe;
	logic                 strobe_d;
	logic                 uio_d;
	sys_pkg::host_word_t  din_d;
	sys_pkg::cmd_phase_t  phase;
	sys_pkg::cmd_code_t   cmd;
	sys_pkg::word_cnt_t   cnt;

	// ==================================================
	// Synchronizer, strobe and acknowledge
	// ==================================================
	assign strobe = bus_s2.io_clk & ~rack;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			bus_s1   <= '0;
			bus_s2   <= '0;
			rack     <= 1'b0;
			io_ack   <= 1'b0;
			strobe_d <= 1'b0;
			uio_d    <= 1'b0;
		end else begin
			bus_s1   <= host_bus;
			bus_s2   <= bus_s1;
			rack     <= bus_s2.io_clk;
			io_ack   <= rack;
			strobe_d <= strobe;
			uio_d    <= bus_s2.io_uio;
		end
	end

	// Data word aligned with strobe_d
	always_ff @(posedge FPGA_CLK2_50) begin
		din_d <= bus_s2.io_din;
	end

	// ==================================================
	// Command decode
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			phase        <= sys_pkg::IDLE;
			cmd          <= '0;
			cnt          <= '0;
			cfg          <= '0;
			video_timing <= sys_pkg::TIMING_RESET_DEFAULT;
			led_override <= '0;
		end else if (!uio_d) begin
			phase <= sys_pkg::IDLE;
		end else if (strobe_d) begin
			if (phase == sys_pkg::IDLE) begin
				// First word after io_uio rises is the command
				phase <= sys_pkg::HAVE_CMD;
				cmd   <= din_d[7:0];
				cnt   <= '0;
			end else begin
				case (cmd)
					sys_pkg::CMD_CFG: begin
						cfg <= sys_pkg::sys_cfg_t'{
							dvi_mode:   din_d[7],
							audio_96k:  din_d[6],
							ypbpr_en:   din_d[5],
							csync:      din_d[3],
							vga_scaler: din_d[2]
						};
					end
					sys_pkg::CMD_TIMING: begin
						if (cnt < sys_pkg::TIMING_WORDS) begin
							cnt <= cnt + 1'b1;
							case (cnt)
								4'd0: video_timing.width  <= din_d[11:0];
								4'd1: video_timing.hfp    <= din_d[11:0];
								4'd2: video_timing.hs     <= din_d[11:0];
								4'd3: video_timing.hbp    <= din_d[11:0];
								4'd4: video_timing.height <= din_d[11:0];
								4'd5: video_timing.vfp    <= din_d[11:0];
								4'd6: video_timing.vs     <= din_d[11:0];
								default: video_timing.vbp <= din_d[11:0];
							endcase
						end
					end
					sys_pkg::CMD_LED: led_override <= sys_pkg::led_override_t'(din_d);
					default: ;
				endcase
			end
		end
	end

	// ==================================================
	// Host side levels and status
	// ==================================================
	assign reset_code    = bus_s2.reset_code;
	assign disk_activity = bus_s2.disk_activity;

	// Host only talks to the core once it has seen the magic
	assign status = bus_s2.core_ready ?
		{1'b0, btn_user, btn_osd, 9'd0, sys_pkg::IO_VER, io_ack, 17'd0} :
		sys_pkg::CORE_MAGIC;

endmodule

// File: verilog/button_debounce.sv
// Debounce of user and OSD buttons, each combined with a board key
// Sampled once per DEBOUNCE_DIV+1 cycles; all inputs are active low
`timescale 1ns/100ps

module button_debounce (
	input  logic       FPGA_CLK2_50,
	input  logic       resetd,
	input  logic       btn_user_n,
	input  logic       btn_osd_n,
	input  logic [1:0] key,
	output logic       btn_user,
	output logic       btn_osd
);

	sys_pkg::debounce_div_t div;
	logic                   tick;
	logic [1:0]             pressed;
	logic [1:0]             btn_q;
	sys_pkg::deb_hist_t     hist [2];

	assign tick       = (div == '0);
	assign pressed[0] = ~(btn_user_n & key[1]);
	assign pressed[1] = ~(btn_osd_n & key[0]);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div   <= '0;
			btn_q <= '0;
			for (int i = 0; i < 2; i++) hist[i] <= '0;
		end else begin
			// Shared sampling divider
			if (div == sys_pkg::debounce_div_t'(sys_pkg::DEBOUNCE_DIV))
				div <= '0;
			else
				div <= div + 1'b1;

			if (tick) begin
				for (int i = 0; i < 2; i++) begin
					hist[i] <= {hist[i][sys_pkg::DEBOUNCE_LEN-2:0], pressed[i]};
					// Level holds between a full and an empty history
					if (&hist[i]) btn_q[i] <= 1'b1;
					if (hist[i] == '0) btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign btn_user = btn_q[0];
	assign btn_osd  = btn_q[1];

endmodule

// File: verilog/reset_request.sv
// Reset request driven by the host code: 1 sets, 0 followed by 2 clears
// A direct jump to 2 from any other code leaves the request set
`timescale 1ns/100ps

module reset_request (
	input  logic                 FPGA_CLK2_50,
	input  logic                 resetd,
	input  sys_pkg::reset_code_t reset_code,
	output logic                 reset_req
);

	sys_pkg::reset_code_t code_d1;
	sys_pkg::reset_code_t code_d2;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			reset_req <= 1'b1;
			code_d1   <= '0;
			code_d2   <= '0;
		end else begin
			code_d1 <= reset_code;
			code_d2 <= code_d1;

			if (code_d1 == 2'd1)
				reset_req <= 1'b1;
			// Release only on the 0 -> 2 sequence
			else if (code_d1 == 2'd2 && code_d2 == 2'd0)
				reset_req <= 1'b0;
		end
	end

endmodule

// File: verilog/audio_mixer.sv
// Stereo cross-mix, purely combinational
// audio_s selects arithmetic shifts for signed samples; sums wrap at 16 bits
`timescale 1ns/100ps

module audio_mixer (
	input  sys_pkg::sample_t   audio_ls,
	input  sys_pkg::sample_t   audio_rs,
	input  logic               audio_s,
	input  sys_pkg::mix_mode_t audio_mix,
	output sys_pkg::sample_t   audio_l,
	output sys_pkg::sample_t   audio_r
);

	// Right shift, sign-aware
	function automatic sys_pkg::sample_t shift_r(
		input sys_pkg::sample_t x,
		input int unsigned      k,
		input logic             sgn
	);
		if (sgn)
			shift_r = $signed(x) >>> k;
		else
			shift_r = x >> k;
	endfunction

	// One output channel from its own and the opposite input
	function automatic sys_pkg::sample_t mix_chan(
		input sys_pkg::sample_t   own,
		input sys_pkg::sample_t   other,
		input sys_pkg::mix_mode_t mode,
		input logic               sgn
	);
		case (mode)
			sys_pkg::MIX_EIGHTH:
				mix_chan = own - shift_r(own, 3, sgn) + shift_r(other, 3, sgn);
			sys_pkg::MIX_QUARTER:
				mix_chan = own - shift_r(own, 2, sgn) + shift_r(other, 2, sgn);
			sys_pkg::MIX_HALF:
				mix_chan = shift_r(own, 1, sgn) + shift_r(other, 1, sgn);
			default:
				mix_chan = own;
		endcase
	endfunction

	assign audio_l = mix_chan(audio_ls, audio_rs, audio_mix, audio_s);
	assign audio_r = mix_chan(audio_rs, audio_ls, audio_mix, audio_s);

endmodule

// File: verilog/vga_sync_out.sv
// Sync polarity fix and VGA sync drive; outputs are active low
// Polarity settles after a few edges; interval counters saturate
`timescale 1ns/100ps

module vga_sync_out (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic hs_in,
	input  logic vs_in,
	input  logic csync,
	output logic vga_hs,
	output logic vga_vs
);

	// Index 0 is hsync, index 1 is vsync
	logic [1:0]         sync_raw;
	logic [1:0]         s1;
	logic [1:0]         s2;
	logic [1:0]         pol;
	logic [1:0]         sync_fix;
	sys_pkg::sync_cnt_t cnt    [2];
	sys_pkg::sync_cnt_t len_hi [2];
	sys_pkg::sync_cnt_t len_lo [2];

	assign sync_raw = {vs_in, hs_in};

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1  <= '0;
			s2  <= '0;
			pol <= '0;
			for (int i = 0; i < 2; i++) begin
				cnt[i]    <= '0;
				len_hi[i] <= '0;
				len_lo[i] <= '0;
			end
		end else begin
			s1 <= sync_raw;
			s2 <= s1;
			for (int i = 0; i < 2; i++) begin
				if (s1[i] != s2[i]) begin
					cnt[i] <= '0;
					// Invert when the high interval is the longer one
					if (s1[i]) begin
						len_lo[i] <= cnt[i];
						pol[i]    <= len_hi[i] > cnt[i];
					end else begin
						len_hi[i] <= cnt[i];
						pol[i]    <= cnt[i] > len_lo[i];
					end
				end else if (cnt[i] != '1) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign sync_fix = sync_raw ^ pol;

	assign vga_hs = csync ? ~(sync_fix[0] ^ sync_fix[1]) : ~sync_fix[0];
	assign vga_vs = csync ? 1'b1 : ~sync_fix[1];

endmodule

// File: verilog/led_panel.sv
// Board LED levels, active high, and the main-board LED byte
// Host override replaces the default bit for each set overtake bit
`timescale 1ns/100ps

module led_panel (
	input  logic                   led_user,
	input  logic [1:0]             led_power,
	input  logic [1:0]             led_disk,
	input  logic                   disk_activity,
	input  sys_pkg::led_override_t led_override,
	output logic                   led_power_on,
	output logic                   led_hdd_on,
	output logic                   led_user_on,
	output logic [7:0]             led
);

	logic [7:0] led_default;

	// Bit 1 forces the level from bit 0
	assign led_power_on = led_power[1] ? led_power[0] : 1'b0;
	assign led_hdd_on   = led_disk[1]  ? led_disk[0]  : (led_disk[0] | disk_activity);
	assign led_user_on  = led_user;

	assign led_default = {
		3'b000,
		led_power_on,
		1'b0,
		led_hdd_on,
		1'b0,
		led_user_on
	};

	// Per-bit mux between default and host state
	assign led = (led_override.overtake & led_override.state) |
		(~led_override.overtake & led_default);

endmodule

// File: verilog/sys_top.sv
// Board glue around a core, all in the FPGA_CLK2_50 domain
// Host bus is asynchronous and resynchronized inside the decoder
`timescale 1ns/100ps

module sys_top (
	input  logic                   FPGA_CLK2_50,
	input  logic                   resetd,
	input  sys_pkg::host_bus_t     host_bus,
	output sys_pkg::status_word_t  status,
	input  logic                   btn_user_n,
	input  logic                   btn_osd_n,
	input  logic [1:0]             key,
	input  sys_pkg::sample_t       audio_ls,
	input  sys_pkg::sample_t       audio_rs,
	input  logic                   audio_s,
	input  sys_pkg::mix_mode_t     audio_mix,
	input  logic                   hs_in,
	input  logic                   vs_in,
	input  logic                   led_user,
	input  logic [1:0]             led_power,
	input  logic [1:0]             led_disk,
	output sys_pkg::sys_cfg_t      cfg,
	output sys_pkg::video_timing_t video_timing,
	output logic                   reset_req,
	output sys_pkg::sample_t       audio_l,
	output sys_pkg::sample_t       audio_r,
	output logic                   VGA_HS,
	output logic                   VGA_VS,
	output logic                   led_power_on,
	output logic                   led_hdd_on,
	output logic                   led_user_on,
	output logic [7:0]             LED
);

	logic                   btn_user;
	logic                   btn_osd;
	sys_pkg::reset_code_t   reset_code;
	logic                   disk_activity;
	sys_pkg::led_override_t led_override;

	// ==================================================
	// Input side
	// ==================================================
	host_cmd_decoder u_host_cmd_decoder (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.host_bus      (host_bus),
		.btn_user      (btn_user),
		.btn_osd       (btn_osd),
		.cfg           (cfg),
		.video_timing  (video_timing),
		.led_override  (led_override),
		.reset_code    (reset_code),
		.disk_activity (disk_activity),
		.status        (status)
	);

	button_debounce u_button_debounce (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.key          (key),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd)
	);

	// ==================================================
	// Processing
	// ==================================================
	reset_request u_reset_request (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.reset_code   (reset_code),
		.reset_req    (reset_req)
	);

	audio_mixer u_audio_mixer (
		.audio_ls  (audio_ls),
		.audio_rs  (audio_rs),
		.audio_s   (audio_s),
		.audio_mix (audio_mix),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	// ==================================================
	// Output side
	// ==================================================
	vga_sync_out u_vga_sync_out (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.hs_in        (hs_in),
		.vs_in        (vs_in),
		.csync        (cfg.csync),
		.vga_hs       (VGA_HS),
		.vga_vs       (VGA_VS)
	);

	led_panel u_led_panel (
		.led_user      (led_user),
		.led_power     (led_power),
		.led_disk      (led_disk),
		.disk_activity (disk_activity),
		.led_override  (led_override),
		.led_power_on  (led_power_on),
		.led_hdd_on    (led_hdd_on),
		.led_user_on   (led_user_on),
		.led           (LED)
	);

endmodule

// File: verification/tb_sys_top.sv
// Testbench for sys_top; stops with $fatal at the first wrong value
// Button checks run real debounce ticks, about 20 ms of simulated time
// Host words are held for 8 cycles per io_clk phase
`timescale 1ns/100ps

module tb_sys_top;

	localparam int     CLK_PERIOD   = 10;
	localparam int     TICK_CYCLES  = sys_pkg::DEBOUNCE_DIV + 1;
	localparam int     DEB_TICKS    = 20;
	localparam longint WATCHDOG_NS  = longint'(DEB_TICKS) * TICK_CYCLES * CLK_PERIOD + 2000000;
	localparam int     PHASE_CYCLES = 8;
	localparam int     HS_PERIOD    = 24;
	localparam int     HS_HIGH      = 4;
	localparam int     VS_PERIOD    = 60;
	localparam int     VS_HIGH      = 8;
	localparam logic [31:0] RANDOM_SEED = 32'h705516a1;

	logic                   FPGA_CLK2_50 = 1'b0;
	logic                   resetd;
	sys_pkg::host_bus_t     host_bus;
	sys_pkg::status_word_t  status;
	logic                   btn_user_n;
	logic                   btn_osd_n;
	logic [1:0]             key;
	sys_pkg::sample_t       audio_ls;
	sys_pkg::sample_t       audio_rs;
	logic                   audio_s;
	sys_pkg::mix_mode_t     audio_mix;
	logic                   hs_in = 1'b0;
	logic                   vs_in = 1'b0;
	logic                   led_user;
	logic [1:0]             led_power;
	logic [1:0]             led_disk;
	sys_pkg::sys_cfg_t      cfg;
	sys_pkg::video_timing_t video_timing;
	logic                   reset_req;
	sys_pkg::sample_t       audio_l;
	sys_pkg::sample_t       audio_r;
	logic                   VGA_HS;
	logic                   VGA_VS;
	logic                   led_power_on;
	logic                   led_hdd_on;
	logic                   led_user_on;
	logic [7:0]             LED;

	logic                   ack_check_en;
	logic [3:0]             clk_hist = '0;
	logic                   sync_run;
	logic                   sync_inv;
	int                     hs_cnt = 0;
	int                     vs_cnt = 0;
	int                     checks_done;
	sys_pkg::sys_cfg_t      cfg_exp;
	logic [31:0]            seed_ret;

	always #(CLK_PERIOD / 2) FPGA_CLK2_50 = ~FPGA_CLK2_50;

	sys_top u_sys_top (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.host_bus     (host_bus),
		.status       (status),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.key          (key),
		.audio_ls     (audio_ls),
		.audio_rs     (audio_rs),
		.audio_s      (audio_s),
		.audio_mix    (audio_mix),
		.hs_in        (hs_in),
		.vs_in        (vs_in),
		.led_user     (led_user),
		.led_power    (led_power),
		.led_disk     (led_disk),
		.cfg          (cfg),
		.video_timing (video_timing),
		.reset_req    (reset_req),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.VGA_HS       (VGA_HS),
		.VGA_VS       (VGA_VS),
		.led_power_on (led_power_on),
		.led_hdd_on   (led_hdd_on),
		.led_user_on  (led_user_on),
		.LED          (LED)
	);

	// ==================================================
	// Reference model
	// ==================================================
	function automatic sys_pkg::sample_t expected_mix(input sys_pkg::sample_t own,
		input sys_pkg::sample_t other, input sys_pkg::mix_mode_t mode, input logic sgn);
		int a;
		int b;
		int r;
		a = sgn ? int'($signed(own)) : int'(own);
		b = sgn ? int'($signed(other)) : int'(other);
		case (mode)
			2'd0: r = a;
			2'd1: r = a - (a >>> 3) + (b >>> 3);
			2'd2: r = a - (a >>> 2) + (b >>> 2);
			default: r = (a >>> 1) + (b >>> 1);
		endcase
		return r[15:0];
	endfunction

	// Words past the eighth never reach the timing struct
	function automatic sys_pkg::video_timing_t expected_timing(input sys_pkg::host_word_t words [10]);
		return {words[0][11:0], words[1][11:0], words[2][11:0], words[3][11:0],
			words[4][11:0], words[5][11:0], words[6][11:0], words[7][11:0]};
	endfunction

	function automatic sys_pkg::sys_cfg_t expected_cfg(input sys_pkg::host_word_t w);
		return {w[7:5], w[3:2]};
	endfunction

	function automatic sys_pkg::status_word_t expected_status(input logic ready,
		input logic bu, input logic bo, input logic ack);
		if (!ready)
			return sys_pkg::CORE_MAGIC;
		return {1'b0, bu, bo, 9'd0, sys_pkg::IO_VER, ack, 17'd0};
	endfunction

	// Returns {power, hdd, user}
	function automatic logic [2:0] expected_board(input logic user, input logic [1:0] pwr,
		input logic [1:0] disk, input logic act);
		logic p;
		logic h;
		p = pwr[1] & pwr[0];
		h = disk[1] ? disk[0] : (disk[0] | act);
		return {p, h, user};
	endfunction

	function automatic logic [7:0] expected_led(input logic [2:0] board,
		input sys_pkg::led_override_t ovr);
		logic [7:0] dflt;
		logic [7:0] res;
		dflt = {3'b000, board[2], 1'b0, board[1], 1'b0, board[0]};
		for (int i = 0; i < 8; i++)
			res[i] = ovr.overtake[i] ? ovr.state[i] : dflt[i];
		return res;
	endfunction

	// Returns {vga_hs, vga_vs}
	function automatic logic [1:0] expected_vga(input logic hs, input logic vs,
		input logic inv, input logic cs);
		logic hs_a;
		logic vs_a;
		hs_a = hs ^ inv;
		vs_a = vs ^ inv;
		if (cs)
			return {hs_a ~^ vs_a, 1'b1};
		return {~hs_a, ~vs_a};
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sample(input string name, input sys_pkg::sample_t got,
		input sys_pkg::sample_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp));
		else
			checks_done++;
	endtask

	task automatic check_timing(input sys_pkg::video_timing_t got,
		input sys_pkg::video_timing_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: video_timing got %h expected %h",
				$time, got, exp));
		else
			checks_done++;
	endtask

	task automatic check_cfg(input sys_pkg::sys_cfg_t got, input sys_pkg::sys_cfg_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: cfg got %b expected %b", $time, got, exp));
		else
			checks_done++;
	endtask

	task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp));
		else
			checks_done++;
	endtask

	task automatic check_status(input sys_pkg::status_word_t got, input sys_pkg::status_word_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: status got %h expected %h", $time, got, exp));
		else
			checks_done++;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp));
		else
			checks_done++;
	endtask

	// io_ack must repeat io_clk four cycles later
	always @(negedge FPGA_CLK2_50) begin
		clk_hist <= {clk_hist[2:0], host_bus.io_clk};
		if (ack_check_en)
			check_bit("io_ack", status[17], clk_hist[3]);
	end

	// Sync source, inverted polarity when sync_inv is set
	always @(posedge FPGA_CLK2_50) begin
		if (sync_run) begin
			hs_cnt <= (hs_cnt == HS_PERIOD - 1) ? 0 : hs_cnt + 1;
			vs_cnt <= (vs_cnt == VS_PERIOD - 1) ? 0 : vs_cnt + 1;
			hs_in  <= (hs_cnt < HS_HIGH) ^ sync_inv;
			vs_in  <= (vs_cnt < VS_HIGH) ^ sync_inv;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Watchdog expired after %0d ns, the tests did not complete",
			WATCHDOG_NS));
	end

	// ==================================================
	// Host bus stimulus
	// ==================================================
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge FPGA_CLK2_50);
	endtask

	task automatic host_word(input sys_pkg::host_word_t w);
		host_bus.io_din <= w;
		host_bus.io_clk <= 1'b1;
		wait_cycles(PHASE_CYCLES);
		host_bus.io_clk <= 1'b0;
		wait_cycles(PHASE_CYCLES);
	endtask

	task automatic host_begin(input sys_pkg::cmd_code_t code);
		host_bus.io_uio <= 1'b1;
		wait_cycles(PHASE_CYCLES);
		host_word({8'h00, code});
	endtask

	task automatic host_end();
		host_bus.io_uio <= 1'b0;
		wait_cycles(PHASE_CYCLES);
	endtask

	task automatic send_cfg(input sys_pkg::host_word_t w);
		host_begin(sys_pkg::CMD_CFG);
		host_word(w);
		host_end();
		cfg_exp = expected_cfg(w);
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic test_after_reset();
		@(negedge FPGA_CLK2_50);
		check_timing(video_timing, sys_pkg::TIMING_RESET_DEFAULT);
		check_cfg(cfg, '0);
		check_led("LED", LED, expected_led(expected_board(led_user, led_power, led_disk, 1'b0), '0));
		check_bit("reset_req", reset_req, 1'b1);
		check_status(status, expected_status(1'b0, 1'b0, 1'b0, 1'b0));
		wait_cycles(1);
		host_bus.core_ready <= 1'b1;
		wait_cycles(5);
		@(negedge FPGA_CLK2_50);
		check_status(status, expected_status(1'b1, 1'b0, 1'b0, 1'b0));
		ack_check_en = 1'b1;
	endtask

	task automatic test_commands();
		sys_pkg::host_word_t words [10];
		logic [31:0]         rnd;
		for (int i = 0; i < 10; i++) begin
			rnd = $urandom();
			words[i] = rnd[15:0];
		end
		wait_cycles(1);
		host_begin(sys_pkg::CMD_TIMING);
		for (int i = 0; i < 10; i++)
			host_word(words[i]);
		host_end();
		@(negedge FPGA_CLK2_50);
		check_timing(video_timing, expected_timing(words));
		// Two words in one command, the second one stays
		rnd = $urandom();
		wait_cycles(1);
		host_begin(sys_pkg::CMD_CFG);
		host_word(rnd[15:0]);
		host_word(rnd[31:16]);
		host_end();
		cfg_exp = expected_cfg(rnd[31:16]);
		@(negedge FPGA_CLK2_50);
		check_cfg(cfg, cfg_exp);
		check_timing(video_timing, expected_timing(words));
	endtask

	task automatic test_reset_codes();
		sys_pkg::reset_code_t seq [9];
		sys_pkg::reset_code_t prev;
		logic                 req;
		seq = '{2'd2, 2'd3, 2'd1, 2'd3, 2'd2, 2'd0, 2'd2, 2'd1, 2'd0};
		prev = 2'd0;
		req = 1'b1;
		for (int i = 0; i < 9; i++) begin
			wait_cycles(1);
			host_bus.reset_code <= seq[i];
			if (seq[i] == 2'd1)
				req = 1'b1;
			else if (seq[i] == 2'd2 && prev == 2'd0)
				req = 1'b0;
			prev = seq[i];
			wait_cycles(8);
			@(negedge FPGA_CLK2_50);
			check_bit("reset_req", reset_req, req);
		end
	endtask

	task automatic test_audio();
		logic [31:0] rnd;
		for (int combo = 0; combo < 8; combo++) begin
			for (int n = 0; n < 200; n++) begin
				wait_cycles(1);
				rnd = $urandom();
				audio_ls  <= rnd[15:0];
				audio_rs  <= rnd[31:16];
				audio_s   <= combo[2];
				audio_mix <= combo[1:0];
				@(negedge FPGA_CLK2_50);
				check_sample("audio_l", audio_l, expected_mix(audio_ls, audio_rs, audio_mix, audio_s));
				check_sample("audio_r", audio_r, expected_mix(audio_rs, audio_ls, audio_mix, audio_s));
			end
		end
	endtask

	task automatic test_leds();
		sys_pkg::led_override_t ovr;
		logic [31:0]            rnd;
		logic [2:0]             board;
		for (int c = 0; c < 4; c++) begin
			rnd = $urandom();
			ovr = rnd[15:0];
			wait_cycles(1);
			host_begin(sys_pkg::CMD_LED);
			host_word(ovr);
			host_end();
			for (int n = 0; n < 16; n++) begin
				rnd = $urandom();
				led_user  <= rnd[0];
				led_power <= rnd[2:1];
				led_disk  <= rnd[4:3];
				host_bus.disk_activity <= rnd[5];
				// Disk activity crosses the bus synchronizer
				wait_cycles(4);
				@(negedge FPGA_CLK2_50);
				board = expected_board(led_user, led_power, led_disk, host_bus.disk_activity);
				check_bit("led_power_on", led_power_on, board[2]);
				check_bit("led_hdd_on", led_hdd_on, board[1]);
				check_bit("led_user_on", led_user_on, board[0]);
				check_led("LED", LED, expected_led(board, ovr));
				wait_cycles(1);
			end
		end
	endtask

	task automatic check_vga(input int cycles);
		logic [1:0] exp;
		repeat (cycles) begin
			@(negedge FPGA_CLK2_50);
			exp = expected_vga(hs_in, vs_in, sync_inv, cfg_exp.csync);
			check_bit("VGA_HS", VGA_HS, exp[1]);
			check_bit("VGA_VS", VGA_VS, exp[0]);
		end
	endtask

	task automatic test_vga();
		// Long high phase first, so polarity must flip
		sync_inv = 1'b1;
		sync_run = 1'b1;
		wait_cycles(1);
		send_cfg(16'h0000);
		wait_cycles(4 * VS_PERIOD);
		check_vga(2 * VS_PERIOD);
		sync_inv = 1'b0;
		wait_cycles(4 * VS_PERIOD);
		check_vga(2 * VS_PERIOD);
		sync_inv = 1'b1;
		wait_cycles(1);
		send_cfg(16'h0008);
		wait_cycles(4 * VS_PERIOD);
		check_vga(2 * VS_PERIOD);
	endtask

	// Follows both debounced buttons through the status word
	task automatic wait_button(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge FPGA_CLK2_50);
			n++;
		end while (status[30] !== level && n < 10 * TICK_CYCLES);
		if (status[30] !== level)
			abort_run($sformatf("User button did not reach %b within 10 debounce ticks", level));
		else if (n < 8 * TICK_CYCLES)
			abort_run($sformatf("User button changed after only %0d cycles", n));
		else
			check_status(status, expected_status(1'b1, level, level, clk_hist[3]));
	endtask

	task automatic test_buttons();
		wait_cycles(1);
		btn_user_n <= 1'b0;
		btn_osd_n  <= 1'b0;
		wait_button(1'b1);
		wait_cycles(1);
		btn_user_n <= 1'b1;
		btn_osd_n  <= 1'b1;
		wait_button(1'b0);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		seed_ret = $urandom(RANDOM_SEED);
		resetd = 1'b1;
		host_bus = '0;
		btn_user_n = 1'b1;
		btn_osd_n = 1'b1;
		key = 2'b11;
		audio_ls = '0;
		audio_rs = '0;
		audio_s = 1'b0;
		audio_mix = '0;
		led_user = 1'b1;
		led_power = 2'b11;
		led_disk = 2'b00;
		ack_check_en = 1'b0;
		sync_run = 1'b0;
		sync_inv = 1'b0;
		checks_done = 0;
		cfg_exp = '0;

		repeat (3) @(posedge FPGA_CLK2_50);
		resetd <= 1'b0;

		test_after_reset();
		test_commands();
		test_reset_codes();
		test_audio();
		test_leds();
		test_vga();
		test_buttons();

		if (checks_done == 0) begin
			abort_run("No checks were executed");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// File: sys_top.f
verilog/sys_pkg.sv
verilog/host_cmd_decoder.sv
verilog/button_debounce.sv
verilog/reset_request.sv
verilog/audio_mixer.sv
verilog/vga_sync_out.sv
verilog/led_panel.sv
verilog/sys_top.sv
verification/tb_sys_top.sv

// File: Makefile
# Verilator simulation of sys_top with the tb_sys_top testbench

TOP = tb_sys_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Mdir obj_dir --top-module $(TOP) -f sys_top.f
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
